/* hdl/periph_config.svh */
// Map assumes word aligned accesses only; regions outside 0 and 1 are unmapped
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus widths
`define PERIPH_DATA_W          32
`define PERIPH_ADDR_W          32
`define PERIPH_OFFSET_W        12
`define PERIPH_REGION_W        4

// Source and target counts
`define PERIPH_NUM_TIMERS      2
`define PERIPH_NUM_EXT_IRQ     2
`define PERIPH_NUM_SRC         4
`define PERIPH_NUM_TGT         2
`define PERIPH_PRIO_W          3

// Region select in address bits 15..12
`define PERIPH_REGION_TIMER    4'h0
`define PERIPH_REGION_IRQ      4'h1

// Timer channel registers in one 16 byte block per channel
`define PERIPH_TMR_STRIDE      16
`define PERIPH_TMR_COUNT       0
`define PERIPH_TMR_CTRL        4
`define PERIPH_TMR_CMP         8

// Interrupt controller registers
`define PERIPH_IRQ_PRIO        0
`define PERIPH_IRQ_PENDING     16
`define PERIPH_IRQ_TGT_BASE    32
`define PERIPH_IRQ_TGT_STRIDE  16
`define PERIPH_IRQ_ENABLE      0
`define PERIPH_IRQ_THRESH      4
`define PERIPH_IRQ_CLAIM       8

`endif

/* hdl/periph_pkg.sv */
// Shared bus and register types; all widths come from periph_config.svh
`include "periph_config.svh"

package periph_pkg;

    // Source id width that also holds id 0 for none
    localparam int SrcIdW = $clog2(`PERIPH_NUM_SRC + 1);

    typedef logic [`PERIPH_DATA_W-1:0]   data_t;
    typedef logic [`PERIPH_ADDR_W-1:0]   addr_t;
    typedef logic [`PERIPH_OFFSET_W-1:0] offset_t;
    typedef logic [`PERIPH_PRIO_W-1:0]   prio_t;
    typedef logic [SrcIdW-1:0]           src_id_t;
    typedef logic [`PERIPH_NUM_SRC-1:0]  src_vec_t;

    // APB request from the bus master
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // Single-cycle register strobe towards one data module
    typedef struct packed {
        logic    wr;
        logic    rd;
        offset_t offset;
        data_t   wdata;
    } reg_req_t;

    typedef enum logic [1:0] {IDLE, ACCESS, RESP} access_state_e;

endpackage

/* hdl/apb_access_fsm.sv */
// Fixed 3-cycle APB slave with no wait states; the master must never stall the response
`include "periph_config.svh"

module apb_access_fsm (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  periph_pkg::apb_req_t bus_req_i,
    output periph_pkg::apb_rsp_t bus_rsp_o,
    output periph_pkg::reg_req_t tmr_req_o,
    output periph_pkg::reg_req_t irq_req_o,
    input  periph_pkg::data_t    tmr_rdata_i,
    input  periph_pkg::data_t    irq_rdata_i
);
    import periph_pkg::*;

    access_state_e              state_q, state_d;
    logic [`PERIPH_REGION_W-1:0] region;
    logic                       upper_zero;
    logic                       tmr_sel, irq_sel, in_access;
    data_t                      rdata_mux, prdata_q;
    logic                       err_q;

    // ------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------
    assign region     = bus_req_i.paddr[`PERIPH_OFFSET_W +: `PERIPH_REGION_W];
    assign upper_zero = bus_req_i.paddr[`PERIPH_ADDR_W-1:`PERIPH_OFFSET_W+`PERIPH_REGION_W] == '0;
    assign tmr_sel    = upper_zero && (region == `PERIPH_REGION_TIMER);
    assign irq_sel    = upper_zero && (region == `PERIPH_REGION_IRQ);
    assign in_access  = (state_q == ACCESS);

    // Strobes reach only the addressed module, and only in ACCESS
    always_comb begin
        tmr_req_o.wr     = in_access && tmr_sel && bus_req_i.pwrite;
        tmr_req_o.rd     = in_access && tmr_sel && !bus_req_i.pwrite;
        tmr_req_o.offset = bus_req_i.paddr[`PERIPH_OFFSET_W-1:0];
        tmr_req_o.wdata  = bus_req_i.pwdata;
        irq_req_o.wr     = in_access && irq_sel && bus_req_i.pwrite;
        irq_req_o.rd     = in_access && irq_sel && !bus_req_i.pwrite;
        irq_req_o.offset = bus_req_i.paddr[`PERIPH_OFFSET_W-1:0];
        irq_req_o.wdata  = bus_req_i.pwdata;
    end

    assign rdata_mux = bus_req_i.pwrite ? '0 :
                       tmr_sel          ? tmr_rdata_i :
                       irq_sel          ? irq_rdata_i : '0;

    // ------------------------------------------------------------
    // Bus phase FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (bus_req_i.psel && bus_req_i.penable) state_d = ACCESS;
            ACCESS:  state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            err_q    <= 1'b0;
            prdata_q <= '0;
        end else begin
            state_q <= state_d;
            // Read data and error captured once per access
            if (in_access) begin
                err_q    <= !(tmr_sel || irq_sel);
                prdata_q <= rdata_mux;
            end
        end
    end

    assign bus_rsp_o.prdata  = prdata_q;
    assign bus_rsp_o.pready  = (state_q == RESP);
    assign bus_rsp_o.pslverr = (state_q == RESP) && err_q;

    // Master side protocol rule
    a_penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_req_i.penable |-> bus_req_i.psel);

endmodule

/* hdl/periph_timer.sv */
// Compare timers without prescaler; compare 0 on an enabled channel fires every cycle
`include "periph_config.svh"

module periph_timer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  periph_pkg::reg_req_t          req_i,
    output periph_pkg::data_t             rdata_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] irq_o
);
    import periph_pkg::*;

    localparam int NumTmr = `PERIPH_NUM_TIMERS;

    data_t             count_q [NumTmr];
    data_t             cmp_q   [NumTmr];
    logic [NumTmr-1:0] en_q;
    logic [NumTmr-1:0] irq_q;
    logic [NumTmr-1:0] wr_count, wr_ctrl, wr_cmp;

    function automatic offset_t reg_off(int t, int r);
        return offset_t'(`PERIPH_TMR_STRIDE * t + r);
    endfunction

    // Write decode per channel
    always_comb begin
        for (int t = 0; t < NumTmr; t++) begin
            wr_count[t] = req_i.wr && (req_i.offset == reg_off(t, `PERIPH_TMR_COUNT));
            wr_ctrl[t]  = req_i.wr && (req_i.offset == reg_off(t, `PERIPH_TMR_CTRL));
            wr_cmp[t]   = req_i.wr && (req_i.offset == reg_off(t, `PERIPH_TMR_CMP));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int t = 0; t < NumTmr; t++) begin
                count_q[t] <= '0;
                cmp_q[t]   <= '0;
            end
            en_q  <= '0;
            irq_q <= '0;
        end else begin
            for (int t = 0; t < NumTmr; t++) begin
                irq_q[t] <= 1'b0;
                // A bus write to count wins over counting
                if (wr_count[t]) begin
                    count_q[t] <= req_i.wdata;
                end else if (en_q[t]) begin
                    if (count_q[t] == cmp_q[t]) begin
                        count_q[t] <= '0;
                        irq_q[t]   <= 1'b1;
                    end else begin
                        count_q[t] <= count_q[t] + 1'b1;
                    end
                end
                if (wr_ctrl[t]) en_q[t]  <= req_i.wdata[0];
                if (wr_cmp[t])  cmp_q[t] <= req_i.wdata;
            end
        end
    end

    // Read mux with unused offsets reading 0
    always_comb begin
        rdata_o = '0;
        for (int t = 0; t < NumTmr; t++) begin
            if (req_i.offset == reg_off(t, `PERIPH_TMR_COUNT)) rdata_o = count_q[t];
            if (req_i.offset == reg_off(t, `PERIPH_TMR_CTRL))  rdata_o = data_t'(en_q[t]);
            if (req_i.offset == reg_off(t, `PERIPH_TMR_CMP))   rdata_o = cmp_q[t];
        end
    end

    assign irq_o = irq_q;

endmodule

/* hdl/irq_ctrl.sv */
// Level gateways only; a claim read with no candidate returns 0 and changes nothing
`include "periph_config.svh"

module irq_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  periph_pkg::reg_req_t       req_i,
    output periph_pkg::data_t          rdata_o,
    input  periph_pkg::src_vec_t       src_i,
    output logic [`PERIPH_NUM_TGT-1:0] irq_o
);
    import periph_pkg::*;

    localparam int NumSrc = `PERIPH_NUM_SRC;
    localparam int NumTgt = `PERIPH_NUM_TGT;

    prio_t             prio_q   [NumSrc];
    src_vec_t          en_q     [NumTgt];
    prio_t             thresh_q [NumTgt];
    src_vec_t          pending_q, pending_d;
    src_vec_t          inflight_q, inflight_d;
    src_id_t           best_id   [NumTgt];
    prio_t             best_prio [NumTgt];
    logic [NumTgt-1:0] claim_rd, claim_wr;

    function automatic offset_t prio_off(int s);
        return offset_t'(`PERIPH_IRQ_PRIO + 4 * s);
    endfunction

    function automatic offset_t tgt_off(int t, int r);
        return offset_t'(`PERIPH_IRQ_TGT_BASE + `PERIPH_IRQ_TGT_STRIDE * t + r);
    endfunction

    // ------------------------------------------------------------
    // Arbitration per target
    // ------------------------------------------------------------
    always_comb begin
        for (int t = 0; t < NumTgt; t++) begin
            best_id[t]   = '0;
            best_prio[t] = '0;
            // Strict compare keeps the lowest id on a tie
            for (int s = 0; s < NumSrc; s++) begin
                if (pending_q[s] && en_q[t][s] && (prio_q[s] > thresh_q[t]) &&
                    (prio_q[s] > best_prio[t])) begin
                    best_id[t]   = src_id_t'(s + 1);
                    best_prio[t] = prio_q[s];
                end
            end
            irq_o[t]    = (best_id[t] != '0);
            claim_rd[t] = req_i.rd && (req_i.offset == tgt_off(t, `PERIPH_IRQ_CLAIM));
            claim_wr[t] = req_i.wr && (req_i.offset == tgt_off(t, `PERIPH_IRQ_CLAIM));
        end
    end

    // ------------------------------------------------------------
    // Gateways, claim and complete
    // ------------------------------------------------------------
    always_comb begin
        pending_d  = pending_q | (src_i & ~pending_q & ~inflight_q);
        inflight_d = inflight_q;
        for (int t = 0; t < NumTgt; t++) begin
            for (int s = 0; s < NumSrc; s++) begin
                if (claim_rd[t] && (best_id[t] == src_id_t'(s + 1))) begin
                    pending_d[s]  = 1'b0;
                    inflight_d[s] = 1'b1;
                end
                if (claim_wr[t] && (req_i.wdata == data_t'(s + 1))) inflight_d[s] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NumSrc; s++) prio_q[s] <= '0;
            for (int t = 0; t < NumTgt; t++) begin
                en_q[t]     <= '0;
                thresh_q[t] <= '0;
            end
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            pending_q  <= pending_d;
            inflight_q <= inflight_d;
            for (int s = 0; s < NumSrc; s++) begin
                if (req_i.wr && (req_i.offset == prio_off(s)))
                    prio_q[s] <= req_i.wdata[`PERIPH_PRIO_W-1:0];
            end
            for (int t = 0; t < NumTgt; t++) begin
                if (req_i.wr && (req_i.offset == tgt_off(t, `PERIPH_IRQ_ENABLE)))
                    en_q[t] <= req_i.wdata[NumSrc-1:0];
                if (req_i.wr && (req_i.offset == tgt_off(t, `PERIPH_IRQ_THRESH)))
                    thresh_q[t] <= req_i.wdata[`PERIPH_PRIO_W-1:0];
            end
        end
    end

    // Read mux; claim data is the current best id
    always_comb begin
        rdata_o = '0;
        if (req_i.offset == offset_t'(`PERIPH_IRQ_PENDING)) rdata_o = data_t'(pending_q);
        for (int s = 0; s < NumSrc; s++) begin
            if (req_i.offset == prio_off(s)) rdata_o = data_t'(prio_q[s]);
        end
        for (int t = 0; t < NumTgt; t++) begin
            if (req_i.offset == tgt_off(t, `PERIPH_IRQ_ENABLE)) rdata_o = data_t'(en_q[t]);
            if (req_i.offset == tgt_off(t, `PERIPH_IRQ_THRESH)) rdata_o = data_t'(thresh_q[t]);
            if (req_i.offset == tgt_off(t, `PERIPH_IRQ_CLAIM))  rdata_o = data_t'(best_id[t]);
        end
    end

    // Gateway and claim together keep the two marks exclusive
    a_pend_xor_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pending_q & inflight_q) == '0);

endmodule

/* hdl/periph_top.sv */
// Peripheral subsystem top; irq_ext_i must be synchronous levels, held until serviced
`include "periph_config.svh"

module periph_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  periph_pkg::apb_req_t           bus_req_i,
    output periph_pkg::apb_rsp_t           bus_rsp_o,
    input  logic [`PERIPH_NUM_EXT_IRQ-1:0] irq_ext_i,
    output logic [`PERIPH_NUM_TGT-1:0]     irq_o
);
    import periph_pkg::*;

    reg_req_t                       tmr_req, irq_req;
    data_t                          tmr_rdata, irq_rdata;
    logic [`PERIPH_NUM_TIMERS-1:0]  tmr_irq;
    src_vec_t                       irq_src;

    // ------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------
    apb_access_fsm u_access (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .bus_req_i   ( bus_req_i ),
        .bus_rsp_o   ( bus_rsp_o ),
        .tmr_req_o   ( tmr_req   ),
        .irq_req_o   ( irq_req   ),
        .tmr_rdata_i ( tmr_rdata ),
        .irq_rdata_i ( irq_rdata )
    );

    periph_timer u_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .req_i   ( tmr_req   ),
        .rdata_o ( tmr_rdata ),
        .irq_o   ( tmr_irq   )
    );

    // Source ids 1..2 are the timers, 3..4 the external lines
    assign irq_src = {irq_ext_i, tmr_irq};

    irq_ctrl u_irq (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .req_i   ( irq_req   ),
        .rdata_o ( irq_rdata ),
        .src_i   ( irq_src   ),
        .irq_o   ( irq_o     )
    );

endmodule

/* sim/tb_clk_gen.sv */
// Free running testbench clock; the period must be even
module tb_clk_gen #(
    parameter int Period = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(Period / 2) clk_o = ~clk_o;

endmodule

/* sim/periph_model.svh */
// Included inside the testbench module; expects clk, bus_req and bus_rsp to exist there
`ifndef PERIPH_MODEL_SVH
`define PERIPH_MODEL_SVH

int unsigned checks;
int unsigned errors;
logic [31:0] lfsr_q = 32'h624b;

// Expected register state
logic [`PERIPH_NUM_TIMERS-1:0][`PERIPH_DATA_W-1:0] m_cmp;
logic [`PERIPH_NUM_TIMERS-1:0]                     m_tmr_en;
logic [`PERIPH_NUM_SRC-1:0][`PERIPH_PRIO_W-1:0]    m_prio;
logic [`PERIPH_NUM_TGT-1:0][`PERIPH_NUM_SRC-1:0]   m_en;
logic [`PERIPH_NUM_TGT-1:0][`PERIPH_PRIO_W-1:0]    m_thresh;
logic [`PERIPH_NUM_SRC-1:0]                        m_pend, m_flight, m_level;

// Galois LFSR stepped once per bit
function automatic bit lfsr_bit();
    bit b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return b;
endfunction

function automatic data_t rand_bits(int n);
    data_t r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[`PERIPH_DATA_W-2:0], lfsr_bit()};
    return r;
endfunction

function automatic addr_t tmr_addr(int t, int r);
    return addr_t'(`PERIPH_TMR_STRIDE * t + r);
endfunction

function automatic addr_t irq_addr(int r);
    return {16'h0, `PERIPH_REGION_IRQ, 12'h0} + addr_t'(r);
endfunction

function automatic addr_t tgt_addr(int t, int r);
    return irq_addr(`PERIPH_IRQ_TGT_BASE + `PERIPH_IRQ_TGT_STRIDE * t + r);
endfunction

task automatic model_clear();
    m_cmp    = '0;
    m_tmr_en = '0;
    m_prio   = '0;
    m_en     = '0;
    m_thresh = '0;
    m_pend   = '0;
    m_flight = '0;
    m_level  = '0;
endtask

// Level gateway pends a high source unless already pending or in flight
task automatic model_gate();
    m_pend = m_pend | (m_level & ~m_flight);
endtask

// Scan from the top priority down with the lowest id first within a level
function automatic int model_best(int t);
    for (int p = (1 << `PERIPH_PRIO_W) - 1; p > int'(m_thresh[t]); p--) begin
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            if (m_pend[s] && m_en[t][s] && (int'(m_prio[s]) == p)) return s + 1;
        end
    end
    return 0;
endfunction

function automatic data_t model_irq();
    data_t v;
    v = '0;
    for (int t = 0; t < `PERIPH_NUM_TGT; t++) v[t] = (model_best(t) != 0);
    return v;
endfunction

task automatic check_eq(input string name, input data_t exp, input data_t act);
    checks++;
    assert (act == exp) else begin
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
endtask

// One APB transfer; pready is due 3 cycles after psel
task automatic bus_access(input bit wr, input addr_t addr, input data_t wdata,
                          output data_t rdata, output bit err);
    int cycles;
    bus_req.psel    = 1'b1;
    bus_req.penable = 1'b0;
    bus_req.pwrite  = wr;
    bus_req.paddr   = addr;
    bus_req.pwdata  = wdata;
    cycles = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
        bus_req.penable = 1'b1;
    end while (!bus_rsp.pready && cycles < 8);
    check_eq($sformatf("pready latency at %h", addr), 3, cycles);
    rdata = bus_rsp.prdata;
    err   = bus_rsp.pslverr;
    bus_req.psel    = 1'b0;
    bus_req.penable = 1'b0;
    bus_req.pwrite  = 1'b0;
endtask

task automatic reg_write(input addr_t addr, input data_t wdata);
    data_t rdata;
    bit    err;
    bus_access(1'b1, addr, wdata, rdata, err);
    check_eq($sformatf("write %h pslverr", addr), 0, data_t'(err));
endtask

task automatic check_read(input string name, input addr_t addr, input data_t exp);
    data_t rdata;
    bit    err;
    bus_access(1'b0, addr, '0, rdata, err);
    check_eq({name, " pslverr"}, 0, data_t'(err));
    check_eq(name, exp, rdata);
endtask

`endif

/* sim/tb_periph_top.sv */
// Random register and interrupt test of periph_top; timers stay disabled during external tests
`include "periph_config.svh"

module tb_periph_top;
    import periph_pkg::*;

    localparam int Rounds = 12;
    localparam int Steps  = 8 + Rounds;

    logic                           clk;
    logic                           rst_n;
    apb_req_t                       bus_req;
    apb_rsp_t                       bus_rsp;
    logic [`PERIPH_NUM_EXT_IRQ-1:0] irq_ext;
    logic [`PERIPH_NUM_TGT-1:0]     irq;

    `include "periph_model.svh"

    tb_clk_gen #(.Period(8)) u_clk (.clk_o(clk));

    periph_top u_dut (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .bus_req_i ( bus_req ),
        .bus_rsp_o ( bus_rsp ),
        .irq_ext_i ( irq_ext ),
        .irq_o     ( irq     )
    );

    task automatic apply_reset();
        rst_n   = 1'b0;
        irq_ext = '0;
        bus_req = '0;
        model_clear();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic check_config_regs(input string name);
        for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
            check_read({name, " cmp"}, tmr_addr(t, `PERIPH_TMR_CMP), m_cmp[t]);
            check_read({name, " ctrl"}, tmr_addr(t, `PERIPH_TMR_CTRL), data_t'(m_tmr_en[t]));
        end
        for (int s = 0; s < `PERIPH_NUM_SRC; s++)
            check_read({name, " prio"}, irq_addr(4 * s), data_t'(m_prio[s]));
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            check_read({name, " enable"}, tgt_addr(t, `PERIPH_IRQ_ENABLE), data_t'(m_en[t]));
            check_read({name, " thresh"}, tgt_addr(t, `PERIPH_IRQ_THRESH), data_t'(m_thresh[t]));
        end
    endtask

    // Claim on target t, then optionally complete the claimed id
    task automatic claim_and_complete(input string name, input int t, input bit complete);
        int id;
        id = model_best(t);
        check_read(name, tgt_addr(t, `PERIPH_IRQ_CLAIM), data_t'(id));
        if (id != 0) begin
            m_pend[id-1]   = 1'b0;
            m_flight[id-1] = 1'b1;
            if (complete) begin
                reg_write(tgt_addr(t, `PERIPH_IRQ_CLAIM), data_t'(id));
                m_flight[id-1] = 1'b0;
                model_gate();
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test steps
    // ------------------------------------------------------------
    task automatic reset_values();
        check_config_regs("reset");
        for (int t = 0; t < `PERIPH_NUM_TIMERS; t++)
            check_read("reset count", tmr_addr(t, `PERIPH_TMR_COUNT), '0);
        check_read("reset pending", irq_addr(`PERIPH_IRQ_PENDING), '0);
        for (int t = 0; t < `PERIPH_NUM_TGT; t++)
            check_read("reset claim", tgt_addr(t, `PERIPH_IRQ_CLAIM), '0);
        check_eq("reset irq_o", '0, data_t'(irq));
    endtask

    task automatic register_readback();
        data_t v;
        for (int t = 0; t < `PERIPH_NUM_TIMERS; t++) begin
            v = rand_bits(32);
            reg_write(tmr_addr(t, `PERIPH_TMR_CMP), v);
            m_cmp[t] = v;
            v = rand_bits(32);
            reg_write(tmr_addr(t, `PERIPH_TMR_CTRL), v);
            m_tmr_en[t] = v[0];
            // Count only holds still on a disabled channel
            if (!v[0]) begin
                v = rand_bits(32);
                reg_write(tmr_addr(t, `PERIPH_TMR_COUNT), v);
                check_read("readback count", tmr_addr(t, `PERIPH_TMR_COUNT), v);
            end
        end
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            v = rand_bits(32);
            reg_write(irq_addr(4 * s), v);
            m_prio[s] = v[`PERIPH_PRIO_W-1:0];
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            v = rand_bits(32);
            reg_write(tgt_addr(t, `PERIPH_IRQ_ENABLE), v);
            m_en[t] = v[`PERIPH_NUM_SRC-1:0];
            v = rand_bits(32);
            reg_write(tgt_addr(t, `PERIPH_IRQ_THRESH), v);
            m_thresh[t] = v[`PERIPH_PRIO_W-1:0];
        end
        check_config_regs("readback");
    endtask

    task automatic unmapped_access();
        addr_t addr;
        data_t rdata;
        bit    err;
        for (int i = 0; i < 8; i++) begin
            addr = rand_bits(32);
            if (i % 2 == 0) begin
                // Mapped region bits with a nonzero bit above them
                addr[16]    = 1'b1;
                addr[15:12] = (i % 4 == 0) ? `PERIPH_REGION_TIMER : `PERIPH_REGION_IRQ;
            end else begin
                addr[31:16] = '0;
                addr[15:12] = 4'h2 + {1'b0, addr[14:12]};
            end
            addr[1:0] = 2'b00;
            bus_access(1'b1, addr, rand_bits(32), rdata, err);
            check_eq("unmapped write pslverr", 1, data_t'(err));
            bus_access(1'b0, addr, '0, rdata, err);
            check_eq("unmapped read pslverr", 1, data_t'(err));
            check_eq("unmapped read prdata", '0, rdata);
        end
        check_config_regs("unmapped");
    endtask

    task automatic timer_interrupt();
        data_t cmp;
        data_t prio;
        int    waited;
        cmp = 4 + rand_bits(5);
        prio = 1 + rand_bits(2);
        reg_write(irq_addr(0), prio);
        m_prio[0] = prio[`PERIPH_PRIO_W-1:0];
        reg_write(tgt_addr(0, `PERIPH_IRQ_ENABLE), 1);
        m_en[0] = 1;
        reg_write(tmr_addr(0, `PERIPH_TMR_CMP), cmp);
        reg_write(tmr_addr(0, `PERIPH_TMR_COUNT), 0);
        reg_write(tmr_addr(0, `PERIPH_TMR_CTRL), 1);
        waited = 0;
        while (!irq[0] && waited < int'(cmp) + 40) begin
            @(posedge clk);
            #1;
            waited++;
        end
        checks++;
        assert (irq[0]) else begin
            errors++;
            $display("Timer 0 interrupt did not reach target 0 within %0d cycles", waited);
        end
        m_pend[0] = 1'b1;
        reg_write(tmr_addr(0, `PERIPH_TMR_CTRL), 0);
        claim_and_complete("timer claim", 0, 1'b1);
        check_read("timer pending", irq_addr(`PERIPH_IRQ_PENDING), data_t'(m_pend));
        check_eq("timer irq_o", model_irq(), data_t'(irq));
    endtask

    task automatic random_arbitration();
        data_t v;
        for (int r = 0; r < Rounds; r++) begin
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                v = rand_bits(3);
                reg_write(irq_addr(4 * s), v);
                m_prio[s] = v[`PERIPH_PRIO_W-1:0];
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                v = rand_bits(4);
                reg_write(tgt_addr(t, `PERIPH_IRQ_ENABLE), v);
                m_en[t] = v[`PERIPH_NUM_SRC-1:0];
                v = rand_bits(2);
                reg_write(tgt_addr(t, `PERIPH_IRQ_THRESH), v);
                m_thresh[t] = v[`PERIPH_PRIO_W-1:0];
            end
            v = rand_bits(2);
            irq_ext = v[`PERIPH_NUM_EXT_IRQ-1:0];
            m_level = {irq_ext, 2'b00};
            model_gate();
            @(posedge clk);
            #1;
            check_eq("random irq_o", model_irq(), data_t'(irq));
            check_read("random pending", irq_addr(`PERIPH_IRQ_PENDING), data_t'(m_pend));
            claim_and_complete("random claim", int'(rand_bits(1)), lfsr_bit());
        end
    endtask

    task automatic claim_until_complete();
        reg_write(irq_addr(8), 5);
        m_prio[2] = 5;
        reg_write(tgt_addr(1, `PERIPH_IRQ_ENABLE), 4'b0100);
        m_en[1] = 4'b0100;
        irq_ext = 2'b01;
        m_level = 4'b0100;
        model_gate();
        @(posedge clk);
        #1;
        check_eq("hold irq_o", model_irq(), data_t'(irq));
        claim_and_complete("hold claim", 1, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        check_read("in flight pending", irq_addr(`PERIPH_IRQ_PENDING), data_t'(m_pend));
        check_eq("in flight irq_o", model_irq(), data_t'(irq));
        reg_write(tgt_addr(1, `PERIPH_IRQ_CLAIM), 3);
        m_flight[2] = 1'b0;
        model_gate();
        check_read("repend pending", irq_addr(`PERIPH_IRQ_PENDING), data_t'(m_pend));
        irq_ext = '0;
        m_level = '0;
        claim_and_complete("repend claim", 1, 1'b1);
        check_read("final pending", irq_addr(`PERIPH_IRQ_PENDING), data_t'(m_pend));
    endtask

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    initial begin
        repeat (Steps * 400) @(posedge clk);
        $display("Watchdog expired after %0d cycles", Steps * 400);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        checks = 0;
        errors = 0;
        apply_reset();
        reset_values();
        repeat (4) register_readback();
        unmapped_access();
        apply_reset();
        timer_interrupt();
        random_arbitration();
        apply_reset();
        claim_until_complete();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
+incdir+sim
hdl/periph_pkg.sv
hdl/apb_access_fsm.sv
hdl/periph_timer.sv
hdl/irq_ctrl.sv
hdl/periph_top.sv
sim/tb_clk_gen.sv
sim/tb_periph_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_periph_top \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
